//--- logic/firFilter_settings.svh
`ifndef FIRFILTER_SETTINGS_SVH
`define FIRFILTER_SETTINGS_SVH

// filter geometry.
`define TAPS 8

// datapath widths.
`define SAMPLE_W 18
`define COEF_W 18
`define ACC_W 48

// wishbone bus widths.
`define WB_ADR_W 4
`define WB_DAT_W 32

// control word sits just above the coefficients.
`define CTRL_ADR 8

`endif

//--- logic/dspPkg.sv
`include "firFilter_settings.svh"

package dspPkg;

    // input and output samples.
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // filter coefficient.
    typedef logic signed [`COEF_W-1:0] coef_t;

    // full precision accumulator.
    typedef logic signed [`ACC_W-1:0] acc_t;

    // output field position.
    typedef logic [4:0] shift_t;

endpackage

//--- logic/busPkg.sv
`include "firFilter_settings.svh"

package busPkg;

    import dspPkg::*;

    typedef logic [`WB_DAT_W-1:0] busWord_t;
    typedef logic [`WB_ADR_W-1:0] busAdr_t;

    // coefficient register layout.
    typedef struct packed {
        logic [`WB_DAT_W-`COEF_W-1:0] pad;
        coef_t                        value;
    } coefWord_t;

    // control register layout.
    typedef struct packed {
        logic [`WB_DAT_W-$bits(shift_t)-1:0] pad;
        shift_t                              value;
    } ctrlWord_t;

    // one bus word read as a coefficient or as the control word.
    typedef union packed {
        busWord_t  raw;
        coefWord_t coef;
        ctrlWord_t ctrl;
    } regWord_u;

endpackage

//--- logic/coefRegs.sv
`include "firFilter_settings.svh"

module coefRegs
    import dspPkg::*;
    import busPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  busAdr_t  wbAdr,
    input  busWord_t wbDatIn,
    output busWord_t wbDatOut,
    output logic     wbAck,
    output coef_t    coefs [`TAPS],
    output shift_t   shift
);

    localparam int idxW = $clog2(`TAPS);

    regWord_u          wrWord;
    regWord_u          rdWord;
    logic              access;
    logic              isCoef;
    logic              isCtrl;
    logic [idxW-1:0]   coefIdx;

    // ack follows one edge after a new access.
    assign access  = wbCyc && wbStb && !wbAck;
    assign isCoef  = (wbAdr < `TAPS);
    assign isCtrl  = (wbAdr == `CTRL_ADR);
    assign coefIdx = wbAdr[idxW-1:0];
    assign wrWord  = wbDatIn;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= access;
        end
    end

    // writes land on the same edge that raises ack.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TAPS; i++) begin
                coefs[i] <= '0;
            end
            shift <= 5'd2;
        end else if (access && wbWe) begin
            if (isCoef) begin
                coefs[coefIdx] <= wrWord.coef.value;
            end else if (isCtrl) begin
                shift <= wrWord.ctrl.value;
            end
        end
    end

    // unused addresses read zero.
    always_comb begin
        rdWord = '0;
        if (isCoef) begin
            rdWord.coef.value = coefs[coefIdx];
        end else if (isCtrl) begin
            rdWord.ctrl.value = shift;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wbDatOut <= rdWord.raw;
        end
    end

endmodule

//--- logic/sampleWindow.sv
`include "firFilter_settings.svh"

module sampleWindow
    import dspPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sampleValid,
    input  sample_t sampleIn,
    output sample_t window [`TAPS],
    output logic    windowValid
);

    // position 0 holds the newest sample.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TAPS; i++) begin
                window[i] <= '0;
            end
        end else if (sampleValid) begin
            window[0] <= sampleIn;
            for (int i = 1; i < `TAPS; i++) begin
                window[i] <= window[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            windowValid <= 1'b0;
        end else begin
            windowValid <= sampleValid;
        end
    end

endmodule

//--- logic/tapMac.sv
`include "firFilter_settings.svh"

module tapMac
    import dspPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    inValid,
    input  sample_t samples [`TAPS/2],
    input  coef_t   coefs [`TAPS/2],
    output acc_t    partialSum,
    output logic    partialValid
);

    localparam int lanes = `TAPS / 2;
    localparam int prodW = `SAMPLE_W + `COEF_W;

    logic signed [prodW-1:0] products [lanes];
    acc_t                    laneSum;

    // full width products are sign extended into the accumulator.
    always_comb begin
        laneSum = '0;
        for (int i = 0; i < lanes; i++) begin
            products[i] = samples[i] * coefs[i];
            laneSum     = laneSum + acc_t'(products[i]);
        end
    end

    always_ff @(posedge clk) begin
        partialSum <= laneSum;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            partialValid <= 1'b0;
        end else begin
            partialValid <= inValid;
        end
    end

endmodule

//--- logic/accumToSample.sv
`include "firFilter_settings.svh"

module accumToSample
    import dspPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    evenValid,
    input  logic    oddValid,
    input  acc_t    evenSum,
    input  acc_t    oddSum,
    input  shift_t  shift,
    output sample_t sampleOut,
    output logic    outValid
);

    // symmetric limits of +/-131071.
    localparam sample_t posLimit = sample_t'((1 << (`SAMPLE_W - 1)) - 1);
    localparam sample_t negLimit = -posLimit;

    // field top sits this far above the shift.
    localparam int fieldTop = `SAMPLE_W - 3;

    acc_t               evenPart;
    acc_t               oddPart;
    acc_t               total;
    logic               totalValid;
    logic [`ACC_W+1:0]  padded;
    acc_t               upper;
    logic               overflow;
    sample_t            field;
    logic               satPos;
    logic               satNeg;
    logic               fieldValid;

    // idle partials contribute zero.
    assign evenPart = evenValid ? evenSum : '0;
    assign oddPart  = oddValid ? oddSum : '0;

    // stage 1 adds the partial sums.
    always_ff @(posedge clk) begin
        total <= evenPart + oddPart;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            totalValid <= 1'b0;
        end else begin
            totalValid <= evenValid;
        end
    end

    // two zero bits below the total cover shifts 0 and 1.
    assign padded = {total, 2'b00};

    // bits 47 down to shift+15 with the sign filled from above.
    assign upper = total >>> (int'(shift) + fieldTop);

    // not all copies of the sign bit.
    assign overflow = (upper != '0) && (upper != '1);

    // stage 2 extracts the field and flags overflow.
    always_ff @(posedge clk) begin
        field  <= padded[shift +: `SAMPLE_W];
        satPos <= overflow && !total[`ACC_W-1];
        satNeg <= overflow && total[`ACC_W-1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fieldValid <= 1'b0;
        end else begin
            fieldValid <= totalValid;
        end
    end

    // stage 3 selects the limit or the field.
    always_ff @(posedge clk) begin
        if (satPos) begin
            sampleOut <= posLimit;
        end else if (satNeg) begin
            sampleOut <= negLimit;
        end else begin
            sampleOut <= field;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= fieldValid;
        end
    end

endmodule

//--- logic/firFilter.sv
`include "firFilter_settings.svh"

module firFilter
    import dspPkg::*;
    import busPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  busAdr_t  wbAdr,
    input  busWord_t wbDatIn,
    output busWord_t wbDatOut,
    output logic     wbAck,
    input  sample_t  sampleIn,
    input  logic     sampleValid,
    output sample_t  sampleOut,
    output logic     outValid
);

    coef_t   coefs [`TAPS];
    shift_t  shift;
    sample_t window [`TAPS];
    logic    windowValid;

    sample_t evenSamples [`TAPS/2];
    sample_t oddSamples [`TAPS/2];
    coef_t   evenCoefs [`TAPS/2];
    coef_t   oddCoefs [`TAPS/2];

    acc_t    evenSum;
    acc_t    oddSum;
    logic    evenValid;
    logic    oddValid;

    coefRegs u_coefRegs (
        .clk      (clk),
        .reset    (reset),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatIn  (wbDatIn),
        .wbDatOut (wbDatOut),
        .wbAck    (wbAck),
        .coefs    (coefs),
        .shift    (shift)
    );

    sampleWindow u_sampleWindow (
        .clk         (clk),
        .reset       (reset),
        .sampleValid (sampleValid),
        .sampleIn    (sampleIn),
        .window      (window),
        .windowValid (windowValid)
    );

    // even taps to one MAC, odd taps to the other.
    for (genvar i = 0; i < `TAPS / 2; i++) begin : splitTaps
        assign evenSamples[i] = window[2*i];
        assign oddSamples[i]  = window[2*i+1];
        assign evenCoefs[i]   = coefs[2*i];
        assign oddCoefs[i]    = coefs[2*i+1];
    end

    tapMac tapEven (
        .clk          (clk),
        .reset        (reset),
        .inValid      (windowValid),
        .samples      (evenSamples),
        .coefs        (evenCoefs),
        .partialSum   (evenSum),
        .partialValid (evenValid)
    );

    tapMac tapOdd (
        .clk          (clk),
        .reset        (reset),
        .inValid      (windowValid),
        .samples      (oddSamples),
        .coefs        (oddCoefs),
        .partialSum   (oddSum),
        .partialValid (oddValid)
    );

    accumToSample u_accumToSample (
        .clk       (clk),
        .reset     (reset),
        .evenValid (evenValid),
        .oddValid  (oddValid),
        .evenSum   (evenSum),
        .oddSum    (oddSum),
        .shift     (shift),
        .sampleOut (sampleOut),
        .outValid  (outValid)
    );

endmodule

//--- bench/firFilterTb.sv
`include "firFilter_settings.svh"

module firFilterTb
    import dspPkg::*;
    import busPkg::*;
();

    localparam int ackTimeout   = 16;
    localparam int drainTimeout = 64;
    localparam int pipeLatency  = 4;

    logic     clk = 1'b0;
    logic     reset;
    logic     wbCyc;
    logic     wbStb;
    logic     wbWe;
    busAdr_t  wbAdr;
    busWord_t wbDatIn;
    busWord_t wbDatOut;
    logic     wbAck;
    sample_t  sampleIn;
    logic     sampleValid;
    sample_t  sampleOut;
    logic     outValid;

    int          cycle = 0;
    int          valueErrors;
    int          otherErrors;
    int          outCount;
    int          sentCount;
    logic [31:0] rngState;
    sample_t     expQ [$];
    int          edgeQ [$];

    firFilter u_firFilter (
        .clk         (clk),
        .reset       (reset),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbDatIn     (wbDatIn),
        .wbDatOut    (wbDatOut),
        .wbAck       (wbAck),
        .sampleIn    (sampleIn),
        .sampleValid (sampleValid),
        .sampleOut   (sampleOut),
        .outValid    (outValid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // coefficient or control layout by address, raw word elsewhere.
    function automatic busWord_t buildWord(input busAdr_t adr, input int value);
        regWord_u word;
        word.raw = '0;
        if (adr < `TAPS) begin
            word.coef.value = coef_t'(value);
        end else if (adr == `CTRL_ADR) begin
            word.ctrl.value = shift_t'(value);
        end else begin
            word.raw = busWord_t'(value);
        end
        return word.raw;
    endfunction

    task automatic checkWord(input string name, input busWord_t expected,
                             input busWord_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkSample(input string name, input sample_t expected,
                               input sample_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkLatency(input string name, input int expected,
                                input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s: expected %0d cycles, actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    // step to just after the next rising edge, then look at the output.
    task automatic nextDrive();
        sample_t expected;
        int      startEdge;
        @(posedge clk);
        #2;
        if (outValid) begin
            if (expQ.size() == 0) begin
                $display("output %0d arrived with no sample pending", sampleOut);
                otherErrors++;
            end else begin
                expected  = expQ.pop_front();
                startEdge = edgeQ.pop_front();
                checkSample($sformatf("output %0d", outCount), expected, sampleOut);
                checkLatency($sformatf("latency %0d", outCount), pipeLatency,
                             cycle - startEdge);
                outCount++;
            end
        end
    endtask

    task automatic drainOutputs();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < drainTimeout) begin
            nextDrive();
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("%0d expected outputs never arrived", expQ.size());
            otherErrors++;
            expQ.delete();
            edgeQ.delete();
        end
    endtask

    task automatic busAccess(input logic write, input busAdr_t adr, input busWord_t data,
                             output busWord_t rdData);
        int waited;
        waited  = 0;
        rdData  = '0;
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        wbWe    = write;
        wbAdr   = adr;
        wbDatIn = data;
        do begin
            nextDrive();
            waited++;
        end while (!wbAck && waited < ackTimeout);
        if (wbAck) begin
            rdData = wbDatOut;
        end else begin
            $display("no wishbone ack for address %0d", adr);
            otherErrors++;
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    // edge 0 is the next rising edge.
    task automatic sendSample(input sample_t value, input sample_t expected, input int gap);
        repeat (gap) begin
            nextDrive();
        end
        sampleIn    = value;
        sampleValid = 1'b1;
        expQ.push_back(expected);
        edgeQ.push_back(cycle + 1);
        sentCount++;
        nextDrive();
        sampleValid = 1'b0;
    endtask

    initial begin
        int       fd;
        int       n;
        int       colA;
        int       colB;
        byte      kind;
        string    line;
        busWord_t rdData;

        reset       = 1'b1;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbDatIn     = '0;
        sampleIn    = '0;
        sampleValid = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        outCount    = 0;
        sentCount   = 0;
        rngState    = 32'h244f;

        repeat (8) begin
            @(posedge clk);
        end
        #2;
        reset = 1'b0;

        // quiet bus and output before any traffic.
        repeat (4) begin
            nextDrive();
            checkFlag("idle wbAck", 1'b0, wbAck);
            checkFlag("idle outValid", 1'b0, outValid);
        end

        fd = $fopen("bench/firFilter_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/firFilter_golden.txt");
            otherErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%c %d %d", kind, colA, colB);
                if (n == 3) begin
                    case (kind)
                        "W": begin
                            drainOutputs();
                            busAccess(1'b1, busAdr_t'(colA),
                                      buildWord(busAdr_t'(colA), colB), rdData);
                        end
                        "R": begin
                            drainOutputs();
                            busAccess(1'b0, busAdr_t'(colA), '0, rdData);
                            checkWord($sformatf("read adr %0d", colA),
                                      buildWord(busAdr_t'(colA), colB), rdData);
                        end
                        "S": begin
                            rngState = xorshift(rngState);
                            sendSample(sample_t'(colA), sample_t'(colB), int'(rngState[1:0]));
                        end
                        "B": sendSample(sample_t'(colA), sample_t'(colB), 0);
                        default: begin
                            $display("unknown line in golden file: %s", line);
                            otherErrors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        drainOutputs();

        if (sentCount == 0) begin
            $display("no samples were read from the golden file");
            otherErrors++;
        end
        $display("outputs checked %0d, value errors %0d, other errors %0d",
                 outCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- bench/firFilter_golden.txt
# W adr data writes a register, R adr data reads one and checks the data.
# S in out sends a sample after a random gap and expects out, B sends it with no gap.
S 1234 0
S 0 0
S 0 0
S 0 0
S 0 0
S 0 0
S 0 0
S 0 0
W 0 1
W 1 -2
W 2 3
W 3 -4
W 4 5
W 5 -6
W 6 7
W 7 -8
W 8 2
W 12 99
R 0 1
R 1 -2
R 2 3
R 3 -4
R 4 5
R 5 -6
R 6 7
R 7 -8
R 8 2
R 12 0
B 1 1
B 0 -2
B 0 3
B 0 -4
B 0 5
B 0 -6
B 0 7
B 0 -8
W 8 0
S 1000 4000
S 1000 -4000
S 1000 8000
S 1000 -8000
W 8 10
S 100000 398
S 100000 -399
S 100000 789
S 100000 -790
W 8 2
S 131071 131071
S -131072 -131071

//--- firFilter.f
+incdir+logic
logic/dspPkg.sv
logic/busPkg.sv
logic/coefRegs.sv
logic/sampleWindow.sv
logic/tapMac.sv
logic/accumToSample.sv
logic/firFilter.sv
bench/firFilterTb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= firFilter.f
TB_TOP     ?= firFilterTb
RTL_TOP    ?= firFilter
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=
PASS_TEXT  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only if the pass message shows up in its output.
sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
